/* Bender.yml */
package:
  name: csr_subsys

sources:
  - verilog/csr_pkg.sv
  - verilog/csr_decode.sv
  - verilog/csr_alu.sv
  - verilog/csr_reg.sv
  - verilog/trap_ctrl.sv
  - verilog/csr_subsys.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_checker.sv
      - testbench/tb_csr_subsys.sv

/* all.f */
verilog/csr_pkg.sv
verilog/csr_decode.sv
verilog/csr_alu.sv
verilog/csr_reg.sv
verilog/trap_ctrl.sv
verilog/csr_subsys.sv
testbench/tb_clk_gen.sv
testbench/tb_checker.sv
testbench/tb_csr_subsys.sv

/* testbench/tb_checker.sv */
//////////////////////////////
// CSR and trap reference model, output compare
//////////////////////////////
`timescale 1ns/1ps

module tb_checker (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        insn_valid_i,
    input  logic [31:0] insn_i,
    input  logic [31:0] insn_pc_i,
    input  logic [31:0] rs1_data_i,
    input  logic        irq_i,
    input  logic [31:0] rd_data_i,
    input  logic        rd_we_i,
    input  logic        stall_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    input  logic        global_int_en_i,
    output int          value_errs_o,
    output int          timing_errs_o
);
    import csr_pkg::*;

    typedef enum {ph_idle, ph_epc, ph_status, ph_cause, ph_ret, ph_redir} phase_e;

    logic [63:0] ref_cycle;
    logic [31:0] ref_mtvec;
    logic [31:0] ref_mcause;
    logic [31:0] ref_mepc;
    logic [31:0] ref_mie;
    logic [31:0] ref_mstatus;
    logic [31:0] ref_mscratch;
    logic [31:0] ref_last_pc;
    logic [31:0] trap_epc;
    logic [31:0] trap_cause;
    logic        ref_ret;     // sequence in flight is an mret
    phase_e      phase;

    initial begin
        value_errs_o  = 0;
        timing_errs_o = 0;
    end

    function automatic logic [31:0] read_csr(input logic [11:0] addr);
        case (addr)
            csr_cycle:    return ref_cycle[31:0];
            csr_cycleh:   return ref_cycle[63:32];
            csr_mtvec:    return ref_mtvec;
            csr_mcause:   return ref_mcause;
            csr_mepc:     return ref_mepc;
            csr_mie:      return ref_mie;
            csr_mstatus:  return ref_mstatus;
            csr_mscratch: return ref_mscratch;
            default:      return '0;
        endcase
    endfunction

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] value);
        case (addr)
            csr_mtvec:    ref_mtvec    = value;
            csr_mcause:   ref_mcause   = value;
            csr_mepc:     ref_mepc     = value;
            csr_mie:      ref_mie      = value;
            csr_mstatus:  ref_mstatus  = value;
            csr_mscratch: ref_mscratch = value;
            default:      ref_mscratch = ref_mscratch;  // counter is read only
        endcase
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            value_errs_o++;
        end
    endtask

    task automatic report_timing(input string what);
        $display("at %0t the trap sequence went wrong: %s", $time, what);
        timing_errs_o++;
    endtask

    always @(posedge clk_i) begin : model_step
        logic [2:0]  f3;
        logic [4:0]  fld;
        logic [11:0] addr;
        logic        is_sys;
        logic        is_csr;
        logic        is_ecall;
        logic        is_mret;
        logic        accept;
        logic        irq_take;
        logic        do_write;
        logic [31:0] old;
        logic [31:0] operand;
        logic [31:0] newval;

        if (!rst_n_i) begin
            ref_cycle    = '0;
            ref_mtvec    = '0;
            ref_mcause   = '0;
            ref_mepc     = '0;
            ref_mie      = '0;
            ref_mstatus  = '0;
            ref_mscratch = '0;
            ref_last_pc  = '0;
            ref_ret      = 1'b0;
            phase        = ph_idle;
        end else begin
            f3       = insn_i[14:12];
            fld      = insn_i[19:15];
            addr     = insn_i[31:20];
            is_sys   = insn_valid_i && (insn_i[6:0] == opc_system);
            is_csr   = is_sys && (f3 != 3'b000) && (f3 != 3'b100);
            is_ecall = is_sys && (insn_i[31:7] == '0);
            is_mret  = is_sys && (insn_i[31:20] == 12'h302) && (insn_i[19:7] == '0);
            accept   = (phase == ph_idle) || (phase == ph_redir);
            irq_take = accept && !insn_valid_i && irq_i
                    && ref_mstatus[mstatus_mie] && ref_mie[mie_meie];

            if (stall_i !== !accept) begin
                report_timing("stall level does not match the sequence");
            end
            if (phase == ph_redir) begin
                if (redirect_i !== 1'b1) begin
                    report_timing("redirect pulse is missing");
                end else begin
                    compare_value("redirect pc", redirect_pc_i, ref_ret ? ref_mepc : ref_mtvec);
                end
            end else if (redirect_i !== 1'b0) begin
                report_timing("redirect came early or without a trap");
            end
            compare_value("global int enable", {31'd0, global_int_en_i},
                          {31'd0, ref_mstatus[mstatus_mie]});

            // rd written only by an accepted CSR access
            compare_value("rd write enable", {31'd0, rd_we_i}, {31'd0, is_csr && accept});

            // old value back to rd
            if (is_csr && accept) begin
                old = read_csr(addr);
                compare_value($sformatf("rd data of csr %h", addr), rd_data_i, old);
                operand = f3[2] ? {27'd0, fld} : rs1_data_i;
                case (f3[1:0])
                    2'b01: begin
                        newval   = operand;
                        do_write = 1'b1;
                    end
                    2'b10: begin
                        newval   = old | operand;
                        do_write = (fld != 5'd0);
                    end
                    default: begin
                        newval   = old & ~operand;
                        do_write = (fld != 5'd0);
                    end
                endcase
                if (do_write) begin
                    write_csr(addr, newval);
                end
            end

            case (phase)
                ph_epc: begin
                    ref_mepc = trap_epc;
                    phase    = ph_status;
                end
                ph_status: begin
                    ref_mstatus[mstatus_mpie] = ref_mstatus[mstatus_mie];
                    ref_mstatus[mstatus_mie]  = 1'b0;
                    phase                     = ph_cause;
                end
                ph_cause: begin
                    ref_mcause = trap_cause;
                    phase      = ph_redir;
                end
                ph_ret: begin
                    ref_mstatus[mstatus_mie]  = ref_mstatus[mstatus_mpie];
                    ref_mstatus[mstatus_mpie] = 1'b1;
                    phase                     = ph_redir;
                end
                default: begin  // idle or redirect cycle may start a new sequence
                    if (is_ecall) begin
                        trap_epc   = insn_pc_i;
                        trap_cause = 32'd11;
                        ref_ret    = 1'b0;
                        phase      = ph_epc;
                    end else if (irq_take) begin
                        trap_epc   = ref_last_pc + 32'd4;
                        trap_cause = 32'h8000_000b;
                        ref_ret    = 1'b0;
                        phase      = ph_epc;
                    end else if (is_mret) begin
                        ref_ret = 1'b1;
                        phase   = ph_ret;
                    end else begin
                        phase = ph_idle;
                    end
                end
            endcase

            if (accept && insn_valid_i) begin
                ref_last_pc = insn_pc_i;
            end
            ref_cycle = ref_cycle + 64'd1;
        end
    end

endmodule

/* testbench/tb_clk_gen.sv */
//////////////////////////////
// testbench clock and reset
//////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* testbench/tb_csr_subsys.sv */
//////////////////////////////
// testbench top, random stimulus and summary
//////////////////////////////
`timescale 1ns/1ps

module tb_csr_subsys;
    import csr_pkg::*;

    localparam int num_steps  = 2000;
    localparam int max_cycles = num_steps * 5 + 100;  // ecall step is the longest

    logic        clk;
    logic        rst_n;
    logic        insn_valid;
    logic [31:0] insn;
    logic [31:0] insn_pc;
    logic [31:0] rs1_data;
    logic        irq;
    logic [31:0] rd_data;
    logic        rd_we;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        global_int_en;
    int          value_errs;
    int          timing_errs;
    int          cycles = 0;
    integer      seed;
    logic [31:0] next_pc;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    csr_subsys #(
        .cycle_width (64)
    ) u_csr_subsys (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .insn_valid_i    (insn_valid),
        .insn_i          (insn),
        .insn_pc_i       (insn_pc),
        .rs1_data_i      (rs1_data),
        .irq_i           (irq),
        .rd_data_o       (rd_data),
        .rd_we_o         (rd_we),
        .stall_o         (stall),
        .redirect_o      (redirect),
        .redirect_pc_o   (redirect_pc),
        .global_int_en_o (global_int_en)
    );

    tb_checker u_checker (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .insn_valid_i    (insn_valid),
        .insn_i          (insn),
        .insn_pc_i       (insn_pc),
        .rs1_data_i      (rs1_data),
        .irq_i           (irq),
        .rd_data_i       (rd_data),
        .rd_we_i         (rd_we),
        .stall_i         (stall),
        .redirect_i      (redirect),
        .redirect_pc_i   (redirect_pc),
        .global_int_en_i (global_int_en),
        .value_errs_o    (value_errs),
        .timing_errs_o   (timing_errs)
    );

    function automatic logic [11:0] pick_addr(input int unsigned idx);
        case (idx)
            0:       return csr_cycle;
            1:       return csr_cycleh;
            2:       return csr_mstatus;
            3:       return csr_mie;
            4:       return csr_mtvec;
            5:       return csr_mscratch;
            6:       return csr_mepc;
            7:       return csr_mcause;
            default: return 12'hF14;  // mhartid, not implemented here
        endcase
    endfunction

    function automatic logic [2:0] pick_funct3(input int unsigned idx);
        case (idx)
            0:       return f3_rw;
            1:       return f3_rs;
            2:       return f3_rc;
            3:       return f3_rwi;
            4:       return f3_rsi;
            default: return f3_rci;
        endcase
    endfunction

    task automatic send(input logic [31:0] word);
        insn       = word;
        insn_pc    = next_pc;
        insn_valid = 1'b1;
        next_pc    = next_pc + 32'd4;
    endtask

    task automatic issue_csr();
        logic [11:0] addr;
        logic [2:0]  f3;
        logic [4:0]  fld;
        logic [4:0]  rd;
        addr = pick_addr($unsigned($random(seed)) % 9);
        f3   = pick_funct3($unsigned($random(seed)) % 6);
        fld  = 5'($random(seed));
        if ($unsigned($random(seed)) % 4 == 0) begin
            fld = 5'd0;  // x0 / zero imm, a plain read for set and clear
        end
        rd       = 5'($random(seed));
        rs1_data = $random(seed);
        send({addr, fld, f3, rd, opc_system});
    endtask

    initial begin
        int unsigned kind;
        insn_valid = 1'b0;
        insn       = '0;
        insn_pc    = '0;
        rs1_data   = '0;
        irq        = 1'b0;
        seed       = 99149;
        next_pc    = 32'h0000_1000;
        wait (rst_n === 1'b1);
        for (int i = 0; i < num_steps; i++) begin
            @(negedge clk);
            insn_valid = 1'b0;
            irq        = 1'b0;
            while (stall) begin
                @(negedge clk);
            end
            kind = $unsigned($random(seed)) % 10;
            if (kind < 6) begin
                issue_csr();
            end else if (kind == 6) begin
                send({25'd0, opc_system});  // ecall
            end else if (kind == 7) begin
                send({f7_mret, rs2_mret, 13'd0, opc_system});
            end else begin
                irq = 1'($random(seed));  // idle cycle
            end
        end
        // let the last trap sequence finish
        @(negedge clk);
        insn_valid = 1'b0;
        irq        = 1'b0;
        while (stall || redirect) begin
            @(negedge clk);
        end
        $display("value errors: %0d, timing errors: %0d", value_errs, timing_errs);
        if (value_errs + timing_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: stimulus did not complete within %0d cycles", max_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

/* verilog/csr_alu.sv */
//////////////////////////////
// CSR read-modify-write
//////////////////////////////
`timescale 1ns/1ps

module csr_alu (
    input  csr_pkg::csr_op_e          op_i,
    input  logic                      use_imm_i,
    input  logic [4:0]                uimm_i,
    input  logic [csr_pkg::xlen-1:0]  rs1_data_i,
    input  logic [csr_pkg::xlen-1:0]  old_i,
    output logic [csr_pkg::xlen-1:0]  wdata_o,
    output logic                      we_o
);
    import csr_pkg::*;

    logic [xlen-1:0] operand;
    logic            field_zero;

    assign operand    = use_imm_i ? xlen'(uimm_i) : rs1_data_i;
    assign field_zero = (uimm_i == 5'd0);  // x0 or zero immediate

    always_comb begin
        wdata_o = old_i;
        we_o    = 1'b0;
        case (op_i)
            op_write: begin
                wdata_o = operand;
                we_o    = 1'b1;
            end
            op_set: begin
                wdata_o = old_i | operand;
                we_o    = !field_zero;  // csrrs with x0 is a pure read
            end
            op_clear: begin
                wdata_o = old_i & ~operand;
                we_o    = !field_zero;
            end
            default: we_o = 1'b0;
        endcase
    end

endmodule

/* verilog/csr_decode.sv */
//////////////////////////////
// SYSTEM instruction decoder
//////////////////////////////
`timescale 1ns/1ps

module csr_decode (
    input  logic             insn_valid_i,
    input  csr_pkg::insn_u   insn_i,
    output csr_pkg::csr_op_e op_o,
    output logic             use_imm_o,
    output logic [4:0]       uimm_o,
    output logic [11:0]      csr_addr_o,
    output logic             rd_we_o,
    output logic             ecall_o,
    output logic             mret_o
);
    import csr_pkg::*;

    logic is_system;
    logic priv_form;

    assign is_system  = insn_valid_i && (insn_i.csr.opcode == opc_system);
    assign csr_addr_o = insn_i.csr.csr_addr;
    assign uimm_o     = insn_i.csr.rs1;  // also the zero test for rs1 forms

    // access forms, csr view
    always_comb begin
        op_o      = op_none;
        use_imm_o = 1'b0;
        if (is_system) begin
            case (insn_i.csr.funct3)
                f3_rw: op_o = op_write;
                f3_rs: op_o = op_set;
                f3_rc: op_o = op_clear;
                f3_rwi: begin
                    op_o      = op_write;
                    use_imm_o = 1'b1;
                end
                f3_rsi: begin
                    op_o      = op_set;
                    use_imm_o = 1'b1;
                end
                f3_rci: begin
                    op_o      = op_clear;
                    use_imm_o = 1'b1;
                end
                default: op_o = op_none;
            endcase
        end
    end

    assign rd_we_o = (op_o != op_none);

    // privileged forms, sys view
    assign priv_form = is_system && (insn_i.sys.funct3 == f3_priv)
                    && (insn_i.sys.rs1 == 5'd0) && (insn_i.sys.rd == 5'd0);
    assign ecall_o   = priv_form && (insn_i.sys.funct7 == 7'd0) && (insn_i.sys.rs2 == 5'd0);
    assign mret_o    = priv_form && (insn_i.sys.funct7 == f7_mret)
                    && (insn_i.sys.rs2 == rs2_mret);

endmodule

/* verilog/csr_pkg.sv */
//////////////////////////////
// CSR addresses, funct3/cause codes, op enum
// instruction word union
//////////////////////////////
package csr_pkg;

    localparam int xlen = 32;

    // machine-mode CSR map
    localparam logic [11:0] csr_cycle    = 12'hC00;
    localparam logic [11:0] csr_cycleh   = 12'hC80;
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_mie      = 12'h304;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;

    localparam logic [2:0] f3_priv = 3'b000;  // ecall / mret
    localparam logic [2:0] f3_rw   = 3'b001;
    localparam logic [2:0] f3_rs   = 3'b010;
    localparam logic [2:0] f3_rc   = 3'b011;
    localparam logic [2:0] f3_rwi  = 3'b101;
    localparam logic [2:0] f3_rsi  = 3'b110;
    localparam logic [2:0] f3_rci  = 3'b111;

    localparam logic [xlen-1:0] cause_ecall     = xlen'(11);
    localparam logic [xlen-1:0] cause_m_ext_irq = {1'b1, (xlen-1)'(11)};  // interrupt flag + 11

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mie_meie     = 11;

    localparam logic [6:0] opc_system = 7'b1110011;
    localparam logic [6:0] f7_mret    = 7'b0011000;
    localparam logic [4:0] rs2_mret   = 5'b00010;

    typedef enum logic [1:0] {
        op_none,
        op_write,
        op_set,
        op_clear
    } csr_op_e;

    // one SYSTEM word, two field layouts
    typedef union packed {
        struct packed {
            logic [11:0] csr_addr;
            logic [4:0]  rs1;     // register index or uimm
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } csr;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } sys;
    } insn_u;

endpackage

/* verilog/csr_reg.sv */
//////////////////////////////
// CSR storage, two write ports, cycle counter
//////////////////////////////
`timescale 1ns/1ps

module csr_reg #(
    parameter int cycle_width = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    // execute port
    input  logic                     we_i,
    input  logic [11:0]              raddr_i,
    input  logic [11:0]              waddr_i,
    input  logic [csr_pkg::xlen-1:0] data_i,
    output logic [csr_pkg::xlen-1:0] data_o,
    // trap port
    input  logic                     trap_we_i,
    input  logic [11:0]              trap_waddr_i,
    input  logic [csr_pkg::xlen-1:0] trap_data_i,
    // straight to the trap FSM
    output logic [csr_pkg::xlen-1:0] mtvec_o,
    output logic [csr_pkg::xlen-1:0] mepc_o,
    output logic [csr_pkg::xlen-1:0] mstatus_o,
    output logic [csr_pkg::xlen-1:0] mie_o,
    output logic                     global_int_en_o
);
    import csr_pkg::*;

    logic [cycle_width-1:0] cycle_q;
    logic [xlen-1:0]        mtvec_q;
    logic [xlen-1:0]        mcause_q;
    logic [xlen-1:0]        mepc_q;
    logic [xlen-1:0]        mie_q;
    logic [xlen-1:0]        mstatus_q;
    logic [xlen-1:0]        mscratch_q;

    logic                   wr_en;
    logic [11:0]            wr_addr;
    logic [xlen-1:0]        wr_data;

    // port A first, trap port otherwise
    assign wr_en   = we_i | trap_we_i;
    assign wr_addr = we_i ? waddr_i : trap_waddr_i;
    assign wr_data = we_i ? data_i : trap_data_i;

    // free running since reset release
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_q    <= '0;
            mcause_q   <= '0;
            mepc_q     <= '0;
            mie_q      <= '0;
            mstatus_q  <= '0;
            mscratch_q <= '0;
        end else if (wr_en) begin
            case (wr_addr)
                csr_mtvec:    mtvec_q    <= wr_data;
                csr_mcause:   mcause_q   <= wr_data;
                csr_mepc:     mepc_q     <= wr_data;
                csr_mie:      mie_q      <= wr_data;
                csr_mstatus:  mstatus_q  <= wr_data;
                csr_mscratch: mscratch_q <= wr_data;
                default:      mscratch_q <= mscratch_q;  // counter and unknown: no effect
            endcase
        end
    end

    // execute read, old value of the addressed CSR
    always_comb begin
        case (raddr_i)
            csr_cycle:    data_o = cycle_q[xlen-1:0];
            csr_cycleh:   data_o = xlen'(cycle_q >> xlen);  // upper bits, zero padded
            csr_mtvec:    data_o = mtvec_q;
            csr_mcause:   data_o = mcause_q;
            csr_mepc:     data_o = mepc_q;
            csr_mie:      data_o = mie_q;
            csr_mstatus:  data_o = mstatus_q;
            csr_mscratch: data_o = mscratch_q;
            default:      data_o = '0;
        endcase
        // a trap-port write in flight is forwarded
        if (trap_we_i && (trap_waddr_i == raddr_i)) begin
            data_o = trap_data_i;
        end
    end

    assign mtvec_o         = mtvec_q;
    assign mepc_o          = mepc_q;
    assign mstatus_o       = mstatus_q;
    assign mie_o           = mie_q;
    assign global_int_en_o = mstatus_q[mstatus_mie];

endmodule

/* verilog/csr_subsys.sv */
//////////////////////////////
// CSR and trap subsystem top
//////////////////////////////
`timescale 1ns/1ps

module csr_subsys #(
    parameter int cycle_width = 64  // 33..64
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     insn_valid_i,
    input  csr_pkg::insn_u           insn_i,
    input  logic [csr_pkg::xlen-1:0] insn_pc_i,
    input  logic [csr_pkg::xlen-1:0] rs1_data_i,
    input  logic                     irq_i,
    output logic [csr_pkg::xlen-1:0] rd_data_o,
    output logic                     rd_we_o,
    output logic                     stall_o,
    output logic                     redirect_o,
    output logic [csr_pkg::xlen-1:0] redirect_pc_o,
    output logic                     global_int_en_o
);
    import csr_pkg::*;

    csr_op_e         csr_op;
    logic            use_imm;
    logic [4:0]      uimm;
    logic [11:0]     csr_addr;
    logic            ecall;
    logic            mret;
    logic [xlen-1:0] csr_wdata;
    logic            csr_we;

    logic            trap_we;
    logic [11:0]     trap_waddr;
    logic [xlen-1:0] trap_data;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mie;

    csr_decode u_csr_decode (
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_i),
        .op_o         (csr_op),
        .use_imm_o    (use_imm),
        .uimm_o       (uimm),
        .csr_addr_o   (csr_addr),
        .rd_we_o      (rd_we_o),
        .ecall_o      (ecall),
        .mret_o       (mret)
    );

    // old value comes back from the register file read
    csr_alu u_csr_alu (
        .op_i       (csr_op),
        .use_imm_i  (use_imm),
        .uimm_i     (uimm),
        .rs1_data_i (rs1_data_i),
        .old_i      (rd_data_o),
        .wdata_o    (csr_wdata),
        .we_o       (csr_we)
    );

    csr_reg #(
        .cycle_width (cycle_width)
    ) u_csr_reg (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .we_i            (csr_we),
        .raddr_i         (csr_addr),
        .waddr_i         (csr_addr),
        .data_i          (csr_wdata),
        .data_o          (rd_data_o),
        .trap_we_i       (trap_we),
        .trap_waddr_i    (trap_waddr),
        .trap_data_i     (trap_data),
        .mtvec_o         (mtvec),
        .mepc_o          (mepc),
        .mstatus_o       (mstatus),
        .mie_o           (mie),
        .global_int_en_o (global_int_en_o)
    );

    trap_ctrl u_trap_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ecall_i       (ecall),
        .mret_i        (mret),
        .insn_valid_i  (insn_valid_i),
        .insn_pc_i     (insn_pc_i),
        .irq_i         (irq_i),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .mstatus_i     (mstatus),
        .mie_i         (mie),
        .trap_we_o     (trap_we),
        .trap_waddr_o  (trap_waddr),
        .trap_data_o   (trap_data),
        .stall_o       (stall_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

/* verilog/trap_ctrl.sv */
//////////////////////////////
// trap entry / mret sequencer
//////////////////////////////
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     ecall_i,
    input  logic                     mret_i,
    input  logic                     insn_valid_i,
    input  logic [csr_pkg::xlen-1:0] insn_pc_i,
    input  logic                     irq_i,
    input  logic [csr_pkg::xlen-1:0] mtvec_i,
    input  logic [csr_pkg::xlen-1:0] mepc_i,
    input  logic [csr_pkg::xlen-1:0] mstatus_i,
    input  logic [csr_pkg::xlen-1:0] mie_i,
    output logic                     trap_we_o,
    output logic [11:0]              trap_waddr_o,
    output logic [csr_pkg::xlen-1:0] trap_data_o,
    output logic                     stall_o,
    output logic                     redirect_o,
    output logic [csr_pkg::xlen-1:0] redirect_pc_o
);
    import csr_pkg::*;

    typedef enum logic [2:0] {
        idle,
        save_epc,
        save_status,
        save_cause,
        ret_status,
        redirect
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic [xlen-1:0] epc_q;
    logic [xlen-1:0] cause_q;
    logic [xlen-1:0] last_pc_q;
    logic            ret_q;    // current sequence is an mret
    logic            accept;
    logic            irq_take;
    logic            start;

    assign accept   = (state_q == idle) || (state_q == redirect);  // not stalled
    assign irq_take = accept && !insn_valid_i && irq_i
                   && mstatus_i[mstatus_mie] && mie_i[mie_meie];
    assign start    = accept && (ecall_i || mret_i || irq_take);

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle, redirect: begin
                if (ecall_i || irq_take) begin
                    state_d = save_epc;
                end else if (mret_i) begin
                    state_d = ret_status;
                end else begin
                    state_d = idle;
                end
            end
            save_epc:    state_d = save_status;
            save_status: state_d = save_cause;
            save_cause:  state_d = redirect;
            ret_status:  state_d = redirect;
            default:     state_d = idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= idle;
            ret_q     <= 1'b0;
            last_pc_q <= '0;
        end else begin
            state_q <= state_d;
            if (start) begin
                ret_q <= mret_i;
            end
            if (accept && insn_valid_i) begin
                last_pc_q <= insn_pc_i;
            end
        end
    end

    // epc and cause latched at entry
    always_ff @(posedge clk_i) begin
        if (accept && ecall_i) begin
            epc_q   <= insn_pc_i;
            cause_q <= cause_ecall;
        end else if (irq_take) begin
            epc_q   <= last_pc_q + xlen'(4);  // resume after last issued insn
            cause_q <= cause_m_ext_irq;
        end
    end

    always_comb begin
        trap_we_o    = 1'b0;
        trap_waddr_o = csr_mepc;
        trap_data_o  = epc_q;
        case (state_q)
            save_epc: trap_we_o = 1'b1;
            save_status: begin
                trap_we_o                 = 1'b1;
                trap_waddr_o              = csr_mstatus;
                trap_data_o               = mstatus_i;
                trap_data_o[mstatus_mpie] = mstatus_i[mstatus_mie];
                trap_data_o[mstatus_mie]  = 1'b0;
            end
            save_cause: begin
                trap_we_o    = 1'b1;
                trap_waddr_o = csr_mcause;
                trap_data_o  = cause_q;
            end
            ret_status: begin
                trap_we_o                 = 1'b1;
                trap_waddr_o              = csr_mstatus;
                trap_data_o               = mstatus_i;
                trap_data_o[mstatus_mie]  = mstatus_i[mstatus_mpie];
                trap_data_o[mstatus_mpie] = 1'b1;
            end
            default: trap_we_o = 1'b0;
        endcase
    end

    assign stall_o       = !accept;
    assign redirect_o    = (state_q == redirect);
    assign redirect_pc_o = ret_q ? mepc_i : mtvec_i;

endmodule
